// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP      = tb_instruction_decode
FILELIST = instruction_decode.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with $(TOOL) and run $(TOP)"
	@echo "make clean  remove $(BUILD)"
	@echo "make help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(BUILD)

// File: hw/decode_pkg.sv
`include "decode_consts.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       word_t;       // Data or address word
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;   // Register index
    typedef logic [`OPCODE_W-1:0]   opcode_t;
    typedef logic [`FUNCT3_W-1:0]   funct3_t;

    // ALU operation, NOP must stay at zero for the cleared issue word
    typedef enum logic [3:0] {
        NOP, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP, MEM_LOAD, MEM_STORE
    } mem_op_e;

    // Access width, also reused as store width
    typedef enum logic [2:0] {
        WORD, BYTE_SIGNED, HALF_SIGNED, BYTE_UNSIGNED, HALF_UNSIGNED
    } wb_type_e;

    typedef enum logic {
        SLOT_EMPTY, SLOT_FULL
    } slot_state_e;

    typedef struct packed {
        word_t instr;       // Raw instruction word
        word_t pc;          // Its address
    } inst_in_t;

    typedef struct packed {
        reg_addr_t rd;      // Destination of the in-flight result
        word_t     result;
    } fwd_entry_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        funct3_t   funct3;
        logic      bit30;   // funct7[5], SUB and SRA select
        word_t     imm_i;
        word_t     imm_s;
        word_t     imm_b;
        word_t     imm_u;
        word_t     imm_j;
        word_t     pc;
    } fields_t;

    typedef struct packed {
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        mem_op_e   mem_op;
        logic      wb_en;       // Register write-back happens
        logic      wb_alu;      // Write-back from ALU, else from memory
        wb_type_e  wb_type;
        reg_addr_t rd;
        word_t     store_data;
        logic      update_pc;   // ALU result is the next PC
        logic      breakpoint;
        logic      bubble;
    } issue_t;

endpackage

// File: hw/inst_slot.sv
`include "decode_consts.svh"

module inst_slot (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  inst_valid,
    input  decode_pkg::inst_in_t  inst,
    input  logic                  take,
    output logic                  full,
    output decode_pkg::fields_t   fields,
    output decode_pkg::reg_addr_t rs1_addr,
    output decode_pkg::reg_addr_t rs2_addr,
    output logic                  inst_credit
);
    import decode_pkg::*;

    slot_state_e state;
    inst_in_t    held;      // Buffered instruction with its PC
    word_t       w;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= SLOT_EMPTY;
            inst_credit <= 1'b0;
        end else begin
            inst_credit <= 1'b0;                 // Single-cycle pulse
            case (state)
                SLOT_EMPTY: begin
                    if (inst_valid) begin
                        state <= SLOT_FULL;      // Upstream spent its credit
                    end
                end
                SLOT_FULL: begin
                    if (take) begin
                        state       <= SLOT_EMPTY;
                        inst_credit <= 1'b1;     // Slot freed, credit goes back
                    end
                end
                default: state <= SLOT_EMPTY;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && state == SLOT_EMPTY) begin
            held <= inst;
        end
    end

    assign full = (state == SLOT_FULL);
    assign w    = held.instr;

    // Field slicing and ISA sign extension
    always_comb begin
        fields.opcode = w[6:0];
        fields.rd     = w[11:7];
        fields.funct3 = w[14:12];
        fields.rs1    = w[19:15];
        fields.rs2    = w[24:20];
        fields.bit30  = w[30];
        fields.imm_i  = {{20{w[31]}}, w[31:20]};
        fields.imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
        fields.imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        fields.imm_u  = {w[31:12], 12'b0};
        fields.imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        fields.pc     = held.pc;
    end

    // Register file read ports, unused sources read x0
    always_comb begin
        rs1_addr = '0;                           // U, J and system formats
        rs2_addr = '0;
        case (fields.opcode)
            `OPC_OP, `OPC_BRANCH, `OPC_STORE: begin
                rs1_addr = fields.rs1;
                rs2_addr = fields.rs2;
            end
            `OPC_OP_IMM, `OPC_LOAD, `OPC_JALR: begin
                rs1_addr = fields.rs1;           // I-type has no rs2
            end
        endcase
    end

endmodule

// File: hw/instruction_decode.sv
`include "decode_consts.svh"

module instruction_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  decode_pkg::inst_in_t   inst,
    input  decode_pkg::word_t      rs1_data,
    input  decode_pkg::word_t      rs2_data,
    input  decode_pkg::fwd_entry_t fwd [`FWD_STAGES],
    input  logic                   issue_credit,
    output logic                   inst_credit,
    output decode_pkg::reg_addr_t  rs1_addr,
    output decode_pkg::reg_addr_t  rs2_addr,
    output logic                   issue_valid,
    output decode_pkg::issue_t     issue
);
    import decode_pkg::*;

    logic    full;               // Slot holds an instruction
    logic    take;               // Issue edge, slot drains
    fields_t fields;
    word_t   src [`NUM_SRC];     // Resolved operands, index 0 is rs1

    inst_slot inst_slot_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .take        (take),
        .full        (full),
        .fields      (fields),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .inst_credit (inst_credit)
    );

    for (genvar i = 0; i < `NUM_SRC; i++) begin : g_fwd
        operand_forward operand_forward_i (
            .src_addr (i == 0 ? rs1_addr : rs2_addr),
            .reg_data (i == 0 ? rs1_data : rs2_data),
            .fwd      (fwd),
            .operand  (src[i])
        );
    end

    issue_controller issue_controller_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .full         (full),
        .fields       (fields),
        .src          (src),
        .issue_credit (issue_credit),
        .take         (take),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

endmodule

// File: hw/issue_control.sv
`include "decode_consts.svh"

module issue_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                full,
    input  decode_pkg::fields_t fields,
    input  decode_pkg::word_t   src [`NUM_SRC],
    input  logic                issue_credit,
    output logic                take,
    output logic                issue_valid,
    output decode_pkg::issue_t  issue
);
    import decode_pkg::*;

    localparam int CNT_W = $clog2(`ISSUE_CREDITS + 1);

    logic [CNT_W-1:0] credits;   // Free downstream entries
    issue_t           nxt;       // Decoded word, loaded at the issue edge
    logic             legal;     // funct3 defined for the class
    logic             has_rd;    // Class writes a destination
    logic             taken;     // Branch condition holds

    // Shared by OP_IMM and OP, SUB only exists in register form
    function automatic alu_op_e alu_decode(input funct3_t f3, input logic bit30,
                                           input logic reg_form);
        alu_op_e op;
        case (f3)
            3'b000:  op = (reg_form && bit30) ? SUB : ADD;
            3'b001:  op = SLL;
            3'b010:  op = SLT;
            3'b011:  op = SLTU;
            3'b100:  op = XOR;
            3'b101:  op = bit30 ? SRA : SRL;
            3'b110:  op = OR;
            default: op = AND;
        endcase
        return op;
    endfunction

    always_comb begin
        case (fields.funct3)
            3'b000:  taken = (src[0] == src[1]);                     // BEQ
            3'b001:  taken = (src[0] != src[1]);                     // BNE
            3'b100:  taken = ($signed(src[0]) <  $signed(src[1]));   // BLT
            3'b101:  taken = ($signed(src[0]) >= $signed(src[1]));   // BGE
            3'b110:  taken = (src[0] <  src[1]);                     // BLTU
            3'b111:  taken = (src[0] >= src[1]);                     // BGEU
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        nxt    = '0;                                  // Inactive no-op
        legal  = 1'b1;
        has_rd = 1'b0;
        case (fields.opcode)
            `OPC_LUI: begin
                has_rd     = 1'b1;
                nxt.op_a   = fields.imm_u;            // B stays zero
                nxt.alu_op = ADD;
            end
            `OPC_AUIPC: begin
                has_rd     = 1'b1;
                nxt.op_a   = fields.imm_u;
                nxt.op_b   = fields.pc;
                nxt.alu_op = ADD;
            end
            `OPC_JAL: begin
                has_rd        = 1'b1;
                nxt.op_a      = fields.imm_j;
                nxt.op_b      = fields.pc;
                nxt.alu_op    = ADD;
                nxt.update_pc = 1'b1;
            end
            `OPC_JALR: begin
                has_rd        = 1'b1;
                nxt.op_a      = fields.imm_i;
                nxt.op_b      = src[0];
                nxt.alu_op    = ADD;
                nxt.update_pc = 1'b1;
            end
            `OPC_BRANCH: begin
                legal         = (fields.funct3[2:1] != 2'b01);   // 010, 011 undefined
                nxt.op_a      = fields.pc;
                nxt.op_b      = fields.imm_b;
                nxt.alu_op    = taken ? ADD : NOP;               // Target only when taken
                nxt.update_pc = taken;
            end
            `OPC_LOAD: begin
                has_rd     = 1'b1;
                nxt.op_a   = src[0];
                nxt.op_b   = fields.imm_i;
                nxt.alu_op = ADD;                     // Effective address
                nxt.mem_op = MEM_LOAD;
                case (fields.funct3)
                    3'b000:  nxt.wb_type = BYTE_SIGNED;     // LB
                    3'b001:  nxt.wb_type = HALF_SIGNED;     // LH
                    3'b010:  nxt.wb_type = WORD;            // LW
                    3'b100:  nxt.wb_type = BYTE_UNSIGNED;   // LBU
                    3'b101:  nxt.wb_type = HALF_UNSIGNED;   // LHU
                    default: legal       = 1'b0;
                endcase
            end
            `OPC_STORE: begin
                nxt.op_a       = src[0];
                nxt.op_b       = fields.imm_s;
                nxt.alu_op     = ADD;
                nxt.mem_op     = MEM_STORE;
                nxt.store_data = src[1];              // Forwarded rs2
                case (fields.funct3)
                    3'b000:  nxt.wb_type = BYTE_SIGNED;     // SB
                    3'b001:  nxt.wb_type = HALF_SIGNED;     // SH
                    3'b010:  nxt.wb_type = WORD;            // SW
                    default: legal       = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                has_rd     = 1'b1;
                nxt.op_a   = src[0];
                nxt.op_b   = fields.imm_i;
                nxt.alu_op = alu_decode(fields.funct3, fields.bit30, 1'b0);
            end
            `OPC_OP: begin
                has_rd     = 1'b1;
                nxt.op_a   = src[0];
                nxt.op_b   = src[1];
                nxt.alu_op = alu_decode(fields.funct3, fields.bit30, 1'b1);
            end
            `OPC_FENCE: begin
                // In-order single issue, ordering already holds
            end
            `OPC_SYSTEM: begin
                // EBREAK only, ECALL passes as a no-op
                nxt.breakpoint = (fields.funct3 == 3'b000) && (fields.imm_i == word_t'(1));
            end
            `OPC_BUBBLE: begin
                nxt.bubble = (fields.rd == '0) && (fields.imm_u == '0);   // Whole word zero
            end
            default: begin
                legal = 1'b0;                         // Unknown opcode
            end
        endcase
        if (!legal) begin
            nxt = '0;
        end else if (has_rd) begin
            nxt.rd     = fields.rd;
            nxt.wb_en  = 1'b1;
            nxt.wb_alu = (fields.opcode != `OPC_LOAD);   // Loads write memory data
        end
    end

    assign take = full && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= CNT_W'(`ISSUE_CREDITS);
        end else if (take && !issue_credit) begin
            credits <= credits - 1'b1;
        end else if (issue_credit && !take) begin
            credits <= credits + 1'b1;               // Both at once cancel out
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            issue       <= '0;                       // Cleared to the inactive no-op
        end else begin
            issue_valid <= take;
            if (take) begin
                issue <= nxt;
            end
        end
    end

endmodule

// File: hw/operand_forward.sv
`include "decode_consts.svh"

module operand_forward (
    input  decode_pkg::reg_addr_t  src_addr,
    input  decode_pkg::word_t      reg_data,
    input  decode_pkg::fwd_entry_t fwd [`FWD_STAGES],
    output decode_pkg::word_t      operand
);

    // Walk from the oldest stage to the youngest so the youngest match wins
    always_comb begin
        operand = reg_data;                          // Register file value by default
        for (int i = `FWD_STAGES - 1; i >= 0; i--) begin
            if (src_addr != '0 && fwd[i].rd == src_addr) begin
                operand = fwd[i].result;             // x0 never forwarded
            end
        end
    end

endmodule

// File: include/decode_consts.svh
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath and register file geometry
`define XLEN        32      // RV32I word
`define REG_ADDR_W  5       // x0..x31
`define OPCODE_W    7       // inst[6:0]
`define FUNCT3_W    3       // inst[14:12]

// Pipeline shape
`define FWD_STAGES     3    // Younger stages offering results
`define NUM_SRC        2    // rs1 and rs2
`define ISSUE_CREDITS  4    // Entries in the downstream buffer

// RV32I major opcodes
`define OPC_LUI     7'b011_0111
`define OPC_AUIPC   7'b001_0111
`define OPC_JAL     7'b110_1111
`define OPC_JALR    7'b110_0111
`define OPC_BRANCH  7'b110_0011   // BEQ..BGEU
`define OPC_LOAD    7'b000_0011   // LB, LH, LW, LBU, LHU
`define OPC_STORE   7'b010_0011   // SB, SH, SW
`define OPC_OP_IMM  7'b001_0011   // Register-immediate ALU group
`define OPC_OP      7'b011_0011   // Register-register ALU group
`define OPC_FENCE   7'b000_1111
`define OPC_SYSTEM  7'b111_0011   // ECALL, EBREAK
`define OPC_BUBBLE  7'b000_0000   // Opcode field of the all-zero word

`endif

// File: instruction_decode.f
+incdir+include
hw/decode_pkg.sv
hw/inst_slot.sv
hw/operand_forward.sv
hw/issue_control.sv
hw/instruction_decode.sv
verification/tb_instruction_decode.sv

// File: verification/tb_instruction_decode.sv
`include "decode_consts.svh"

module tb_instruction_decode;
    timeunit 1ns;
    timeprecision 100ps;
    import decode_pkg::*;

    localparam int PERIOD   = 8;
    localparam int SEED     = 6;
    localparam int N_ALU    = 60;                       // Random OP and OP_IMM
    localparam int N_FWD    = 40;                       // Overlapping forward cases
    localparam int N_BRANCH = 30;                       // Six compares, five value pairs
    localparam int N_MISC   = 21;
    localparam int N_CREDIT = `ISSUE_CREDITS + 1;       // One more than downstream holds
    localparam int N_INSTR  = N_ALU + N_FWD + N_BRANCH + N_MISC + N_CREDIT;
    localparam int WATCHDOG = (N_INSTR * 40 + 16) * PERIOD;

    localparam word_t      PAIR_A [5] = '{32'd5, 32'd3, 32'd9, 32'hFFFF_FFF0, 32'd4};
    localparam word_t      PAIR_B [5] = '{32'd5, 32'd9, 32'd3, 32'd4, 32'h8000_0000};
    localparam logic [2:0] BR_F3  [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // EBREAK, ECALL and the zero word
    localparam word_t      SYS_WORDS [3] = '{32'h0010_0073, 32'h0000_0073, 32'h0};
    // funct3 and opcode, invalid funct3 and unknown opcode included
    localparam logic [9:0] MISC_OPS [18] = '{
        {3'd0, `OPC_LOAD}, {3'd1, `OPC_LOAD}, {3'd2, `OPC_LOAD}, {3'd4, `OPC_LOAD},
        {3'd5, `OPC_LOAD}, {3'd3, `OPC_LOAD}, {3'd0, `OPC_STORE}, {3'd1, `OPC_STORE},
        {3'd2, `OPC_STORE}, {3'd4, `OPC_STORE}, {3'd0, `OPC_LUI}, {3'd0, `OPC_AUIPC},
        {3'd0, `OPC_JAL}, {3'd0, `OPC_JALR}, {3'd0, `OPC_FENCE}, {3'd2, `OPC_BRANCH},
        {3'd0, 7'h7F}, {3'd0, `OPC_BUBBLE}
    };

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    inst_in_t    inst;
    word_t       rs1_data;
    word_t       rs2_data;
    fwd_entry_t  fwd [`FWD_STAGES];
    logic        issue_credit = 1'b0;
    logic        inst_credit;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    logic        issue_valid;
    issue_t      issue;

    word_t       regs [32];                             // Register file contents
    issue_t      expected_q [$];                        // Oldest pending instruction first
    logic [31:0] lcg_state;
    logic        hold_credits;                          // Downstream stalls
    int          value_errors    = 0;
    int          protocol_errors = 0;
    int          sent     = 0;
    int          returned = 0;                          // inst_credit pulses seen
    int          issued   = 0;
    int          owed     = 0;                          // Credits downstream still holds

    instruction_decode instruction_decode_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .fwd          (fwd),
        .issue_credit (issue_credit),
        .inst_credit  (inst_credit),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t regfile_read(input reg_addr_t a);
        return (a == '0) ? '0 : regs[a];                // x0 hardwired
    endfunction

    always_comb rs1_data = regfile_read(rs1_addr);
    always_comb rs2_data = regfile_read(rs2_addr);

    // First match from the youngest stage, x0 never forwarded
    function automatic word_t operand_value(input reg_addr_t r);
        if (r == '0) return '0;
        for (int s = 0; s < `FWD_STAGES; s++) begin
            if (fwd[s].rd == r) return fwd[s].result;
        end
        return regs[r];
    endfunction

    function automatic alu_op_e alu_expect(input logic [2:0] f3, input logic b30,
                                           input logic reg_form);
        alu_op_e tbl [8];
        tbl = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
        if (f3 == 3'd5 && b30) return SRA;
        if (f3 == 3'd0 && b30 && reg_form) return SUB; // No SUBI in the ISA
        return tbl[f3];
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
        logic lt;
        lt = f3[1] ? (a < b) : ($signed(a) < $signed(b));   // BLTU/BGEU unsigned
        case (f3)
            3'd0:       return a == b;
            3'd1:       return a != b;
            3'd4, 3'd6: return lt;
            3'd5, 3'd7: return !lt;
            default:    return 1'b0;
        endcase
    endfunction

    // Size and signedness from funct3, bit 2 marks unsigned loads
    function automatic wb_type_e access_type(input logic [2:0] f3);
        if (f3[1:0] == 2'b10) return WORD;
        if (f3[1:0] == 2'b01) return f3[2] ? HALF_UNSIGNED : HALF_SIGNED;
        return f3[2] ? BYTE_UNSIGNED : BYTE_SIGNED;
    endfunction

    // Read ports by format, rs1 in the upper half
    function automatic logic [9:0] source_addrs(input word_t ins);
        case (ins[6:0])
            `OPC_OP, `OPC_BRANCH, `OPC_STORE:   return {ins[19:15], ins[24:20]};   // R, B, S
            `OPC_OP_IMM, `OPC_LOAD, `OPC_JALR: return {ins[19:15], 5'd0};         // I-type
            default:                           return '0;                         // U, J, others
        endcase
    endfunction

    function automatic issue_t expect_issue(input word_t ins, input word_t pc);
        issue_t     e;
        logic [2:0] f3;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        logic       writes_rd;
        logic       legal;
        f3        = ins[14:12];
        a         = operand_value(ins[19:15]);
        b         = operand_value(ins[24:20]);
        imm_i     = word_t'($signed(ins[31:20]));
        imm_s     = word_t'($signed({ins[31:25], ins[11:7]}));
        imm_b     = word_t'($signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        imm_j     = word_t'($signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        e         = '0;
        writes_rd = 1'b1;
        legal     = 1'b1;
        case (ins[6:0])
            `OPC_LUI, `OPC_AUIPC: begin
                e.alu_op = ADD;
                e.op_a   = {ins[31:12], 12'h000};
                e.op_b   = (ins[6:0] == `OPC_AUIPC) ? pc : '0;
            end
            `OPC_JAL, `OPC_JALR: begin
                e.alu_op    = ADD;
                e.op_a      = (ins[6:0] == `OPC_JAL) ? imm_j : imm_i;
                e.op_b      = (ins[6:0] == `OPC_JAL) ? pc : a;
                e.update_pc = 1'b1;
            end
            `OPC_BRANCH: begin
                writes_rd   = 1'b0;
                legal       = (f3 != 3'd2) && (f3 != 3'd3);
                e.op_a      = pc;
                e.op_b      = imm_b;
                e.update_pc = branch_taken(f3, a, b);
                e.alu_op    = e.update_pc ? ADD : NOP;
            end
            `OPC_LOAD: begin
                legal     = (f3 != 3'd3) && (f3 < 3'd6);
                e.alu_op  = ADD;
                e.op_a    = a;
                e.op_b    = imm_i;
                e.mem_op  = MEM_LOAD;
                e.wb_type = access_type(f3);
            end
            `OPC_STORE: begin
                writes_rd    = 1'b0;
                legal        = (f3 <= 3'd2);
                e.alu_op     = ADD;
                e.op_a       = a;
                e.op_b       = imm_s;
                e.mem_op     = MEM_STORE;
                e.store_data = b;
                e.wb_type    = access_type(f3);
            end
            `OPC_OP_IMM, `OPC_OP: begin
                e.op_a   = a;
                e.op_b   = (ins[6:0] == `OPC_OP) ? b : imm_i;
                e.alu_op = alu_expect(f3, ins[30], ins[6:0] == `OPC_OP);
            end
            `OPC_SYSTEM: begin
                writes_rd    = 1'b0;
                e.breakpoint = (f3 == 3'd0) && (ins[31:20] == 12'h001);   // EBREAK
            end
            `OPC_FENCE: writes_rd = 1'b0;
            `OPC_BUBBLE: begin
                writes_rd = 1'b0;
                e.bubble  = (ins == '0);
            end
            default: legal = 1'b0;
        endcase
        if (!legal) return '0;                          // Issues as inactive no-op
        if (writes_rd) begin
            e.rd     = ins[11:7];
            e.wb_en  = 1'b1;
            e.wb_alu = (ins[6:0] != `OPC_LOAD);
        end
        return e;
    endfunction

    // Legal ALU encoding, funct7 only where SUB, SRA or SRAI use it
    function automatic word_t alu_word(input word_t w, input logic reg_form);
        logic keep_b30;
        w[6:0]   = reg_form ? `OPC_OP : `OPC_OP_IMM;
        keep_b30 = (w[14:12] == 3'd5) || (reg_form && w[14:12] == 3'd0);
        if (reg_form || w[13:12] == 2'b01) begin
            w[31:25] = {1'b0, w[30] & keep_b30, 5'b00000};
        end
        return w;
    endfunction

    function automatic reg_addr_t small_reg();
        logic [31:0] r;
        r = next_random();
        return {3'b000, r[17:16]};                      // x0..x3
    endfunction

    task automatic clear_fwd();
        for (int s = 0; s < `FWD_STAGES; s++) begin
            fwd[s].rd     = '0;
            fwd[s].result = next_random();
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED at %0d ns: %s got %h expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    // Called on a falling edge, spends the single upstream credit
    task automatic send(input word_t ins);
        word_t      pc;
        logic [9:0] addrs;
        while (1 + returned - sent <= 0) begin
            @(negedge clk);
        end
        pc = next_random() & ~32'h3;
        expected_q.push_back(expect_issue(ins, pc));
        inst.instr = ins;
        inst.pc    = pc;
        inst_valid = 1'b1;
        sent++;
        @(negedge clk);
        inst_valid = 1'b0;
        addrs      = source_addrs(ins);                 // Slot holds ins until the issue edge
        check_field("rs1_addr", rs1_addr, addrs[9:5]);
        check_field("rs2_addr", rs2_addr, addrs[4:0]);
    endtask

    task automatic drain();
        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic compare_issue(input issue_t got, input issue_t exp);
        check_field("issue.alu_op", got.alu_op, exp.alu_op);
        check_field("issue.op_a", got.op_a, exp.op_a);
        check_field("issue.op_b", got.op_b, exp.op_b);
        check_field("issue.mem_op", got.mem_op, exp.mem_op);
        check_field("issue.wb_en", got.wb_en, exp.wb_en);
        check_field("issue.wb_alu", got.wb_alu, exp.wb_alu);
        check_field("issue.wb_type", got.wb_type, exp.wb_type);
        check_field("issue.rd", got.rd, exp.rd);
        check_field("issue.store_data", got.store_data, exp.store_data);
        check_field("issue.update_pc", got.update_pc, exp.update_pc);
        check_field("issue.breakpoint", got.breakpoint, exp.breakpoint);
        check_field("issue.bubble", got.bubble, exp.bubble);
    endtask

    always @(posedge clk) begin
        if (inst_credit) returned++;                    // Pulse set on the previous edge
    end

    // Downstream buffer frees one entry a cycle after each issue
    always @(negedge clk) begin
        issue_credit = 1'b0;
        if (!hold_credits && owed > 0) begin
            issue_credit = 1'b1;
            owed--;
        end
        if (rst_n && issue_valid) owed++;
    end

    always @(negedge clk) begin
        if (rst_n && issue_valid) begin
            issued++;
            assert (expected_q.size() != 0) else begin
                $display("ERROR at %0d ns: issue_valid rose with no instruction sent", $time);
                protocol_errors++;
            end
            if (expected_q.size() != 0) begin
                compare_issue(issue, expected_q.pop_front());
            end
        end
    end

    initial begin
        #(WATCHDOG);
        $display("ERROR: timeout after %0d ns, the DUT stopped issuing", WATCHDOG);
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        word_t w;
        int    base;
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        hold_credits = 1'b0;
        lcg_state    = SEED;
        for (int r = 0; r < 32; r++) begin
            regs[r] = (r == 0) ? '0 : next_random();
        end
        clear_fwd();
        for (int c = 0; c < 20; c++) begin              // 16 in reset, 4 idle after
            @(negedge clk);
            check_field("issue_valid", issue_valid, 1'b0);
            check_field("inst_credit", inst_credit, 1'b0);
            if (c == 15) rst_n = 1'b1;
        end

        for (int n = 0; n < N_ALU; n++) begin
            send(alu_word(next_random(), n[0]));        // Every fwd rd is x0
        end
        drain();

        // Sources and forward targets among x0..x3
        for (int n = 0; n < N_FWD; n++) begin
            for (int s = 0; s < `FWD_STAGES; s++) begin
                fwd[s].rd     = small_reg();
                fwd[s].result = next_random();
            end
            w        = alu_word(next_random(), 1'b1);
            w[19:15] = small_reg();
            w[24:20] = small_reg();
            send(w);
            drain();                                    // fwd fixed until issue
        end

        // Operands arrive through stages 0 and 1
        clear_fwd();
        for (int p = 0; p < 5; p++) begin
            fwd[0].rd     = 5'd1;
            fwd[0].result = PAIR_A[p];
            fwd[1].rd     = 5'd2;
            fwd[1].result = PAIR_B[p];
            for (int k = 0; k < 6; k++) begin
                w        = next_random();
                w[6:0]   = `OPC_BRANCH;
                w[14:12] = BR_F3[k];
                w[19:15] = 5'd1;
                w[24:20] = 5'd2;
                send(w);
            end
            drain();
        end

        clear_fwd();
        for (int k = 0; k < 18; k++) begin
            w        = next_random();
            w[6:0]   = MISC_OPS[k][6:0];
            w[14:12] = MISC_OPS[k][9:7];
            send(w);
        end
        for (int k = 0; k < 3; k++) begin
            send(SYS_WORDS[k]);
        end
        drain();

        // Downstream withholds credits
        repeat (4) @(negedge clk);                      // Outstanding credits settle
        hold_credits = 1'b1;
        base         = issued;
        for (int n = 0; n < N_CREDIT; n++) begin
            send(alu_word(next_random(), 1'b1));
        end
        repeat (20) @(negedge clk);
        @(posedge clk);
        check_field("issue_valid count", issued - base, `ISSUE_CREDITS);
        check_field("inst_credit count", returned, sent - 1);   // Last one still in slot
        hold_credits = 1'b0;
        drain();

        repeat (10) @(negedge clk);
        assert (expected_q.size() == 0) else begin
            $display("ERROR: %0d sent instructions never issued", expected_q.size());
            protocol_errors++;
        end
        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
